//--- source/pred_cfg_pkg.sv
`default_nettype none

// fetch address and BTB geometry
package pred_cfg_pkg;

	// instruction address width
	localparam int word_size = 16;

	// low pc bits that pick a BTB entry
	localparam int btb_index_width = 8;

	localparam int btb_depth = 1 << btb_index_width; // one entry per index value

	// program counter or branch target
	typedef logic [word_size-1:0] word_t;

	// BTB entry select, taken straight from pc
	typedef logic [btb_index_width-1:0] btb_index_t;

endpackage

`default_nettype wire

//--- source/pred_state_pkg.sv
`default_nettype none

// encoding of the global direction counter
package pred_state_pkg;

	localparam int counter_width = 2;

	// msb set means the counter currently predicts taken
	typedef enum logic [counter_width-1:0] {
		strongly_not_taken = 2'd0,
		weakly_not_taken   = 2'd1,
		weakly_taken       = 2'd2,
		strongly_taken     = 2'd3
	} counter_state_t;

endpackage

`default_nettype wire

//--- source/target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

// direct-mapped branch target buffer, no tags
// PCs sharing the low index bits alias onto one entry
module target_buffer
	import pred_cfg_pkg::*;
(
	input  wire logic       clk,
	input  wire logic       reset_n,

	// lookup port, asynchronous
	input  wire btb_index_t read_index,
	output logic            hit,
	output word_t           target,

	// update port, written on the rising edge
	input  wire logic       write_en,
	input  wire btb_index_t write_index,
	input  wire word_t      write_target
);

	logic [btb_depth-1:0] valid; // one bit per entry
	word_t                targets [btb_depth];

	logic [btb_depth-1:0] valid_set; // one-hot of the entry being written

	always_comb begin
		valid_set = '0;
		if (write_en) begin
			valid_set[write_index] = 1'b1;
		end
	end

	// reset drops every entry at once
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			valid <= '0;
		end else begin
			valid <= valid | valid_set;
		end
	end

	// target storage itself is never cleared, valid gates it
	always_ff @(posedge clk) begin
		if (write_en) begin
			targets[write_index] <= write_target;
		end
	end

	// reads see the contents from before this cycle's write
	always_comb begin
		hit    = valid[read_index];
		target = targets[read_index];
	end

endmodule

`default_nettype wire

//--- source/direction_counter.sv
`timescale 1ns/1ps
`default_nettype none

// global 2-bit saturating direction counter
// the next state comes from the snapshot carried down the pipeline,
// not from the live register
module direction_counter
	import pred_state_pkg::*;
(
	input  wire logic           clk,
	input  wire logic           reset_n,
	input  wire logic           update,     // resolved branch or jump this cycle
	input  wire logic           outcome,    // actual direction
	input  wire counter_state_t prev_state, // state seen when the branch was fetched
	output counter_state_t      state
);

	counter_state_t next_state;

	// transition table
	always_comb begin
		next_state = state; // hold when nothing resolves
		if (update) begin
			unique case (prev_state)
				strongly_not_taken: begin
					if (outcome) begin
						next_state = weakly_not_taken;
					end else begin
						next_state = strongly_not_taken; // saturate low
					end
				end
				weakly_not_taken: begin
					if (outcome) begin
						next_state = weakly_taken;
					end else begin
						next_state = strongly_not_taken;
					end
				end
				weakly_taken: begin
					if (outcome) begin
						next_state = strongly_taken;
					end else begin
						next_state = weakly_not_taken;
					end
				end
				strongly_taken: begin
					if (outcome) begin
						next_state = strongly_taken; // saturate high
					end else begin
						next_state = weakly_taken;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= strongly_not_taken;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

//--- source/branch_predictor.sv
`timescale 1ns/1ps
`default_nettype none

// fetch-stage branch predictor
// lookup is combinational off pc, updates come from the resolve stage
module branch_predictor
	import pred_cfg_pkg::*;
	import pred_state_pkg::*;
(
	input  wire logic           clk,
	input  wire logic           reset_n,

	// fetch side
	input  wire word_t          pc,

	// resolve side
	input  wire logic           is_bj,
	input  wire word_t          branch_pc,
	input  wire word_t          actual_pc,
	input  wire logic           actual_taken,
	input  wire counter_state_t prev_state,

	// prediction
	output word_t               next_pc,
	output logic                taken,
	output counter_state_t      predictor_state // snapshot for the pipeline to carry
);

	btb_index_t     read_index;
	btb_index_t     write_index;
	logic           btb_write_en;
	logic           btb_hit;
	word_t          btb_target;
	counter_state_t counter_state;
	word_t          fall_through;

	assign read_index  = pc[btb_index_width-1:0];
	assign write_index = branch_pc[btb_index_width-1:0];

	// only taken branches allocate, a not-taken one leaves its entry alone
	assign btb_write_en = is_bj && actual_taken;

	target_buffer u_target_buffer (
		.clk          (clk),
		.reset_n      (reset_n),
		.read_index   (read_index),
		.hit          (btb_hit),
		.target       (btb_target),
		.write_en     (btb_write_en),
		.write_index  (write_index),
		.write_target (actual_pc)
	);

	direction_counter u_direction_counter (
		.clk        (clk),
		.reset_n    (reset_n),
		.update     (is_bj),
		.outcome    (actual_taken),
		.prev_state (prev_state),
		.state      (counter_state)
	);

	assign fall_through = pc + word_t'(1);

	// weakly or strongly taken, and a known target for this pc
	assign taken = counter_state[1] && btb_hit;

	always_comb begin
		if (taken) begin
			next_pc = btb_target;
		end else begin
			next_pc = fall_through;
		end
	end

	assign predictor_state = counter_state;

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns    = 4,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// released on a falling edge, away from the sampling edge
	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- test/branch_predictor_checker.sv
`timescale 1ns/1ps
`default_nettype none

// port-level properties of the predictor
module branch_predictor_checker
	import pred_cfg_pkg::*;
	import pred_state_pkg::*;
(
	input wire logic           clk,
	input wire logic           reset_n,
	input wire word_t          pc,
	input wire logic           is_bj,
	input wire logic           actual_taken,
	input wire counter_state_t prev_state,
	input wire word_t          next_pc,
	input wire logic           taken,
	input wire counter_state_t predictor_state
);

	// reset empties the BTB and drops the counter
	taken_after_reset: assert property (@(posedge clk) !reset_n |=> !taken)
		else $error("taken is set in the cycle after reset");

	taken_needs_taken_state: assert property (@(posedge clk) disable iff (!reset_n)
		taken |-> (predictor_state == weakly_taken || predictor_state == strongly_taken))
		else $error("taken is set while the counter predicts not taken");

	fall_through_when_not_taken: assert property (@(posedge clk) disable iff (!reset_n)
		!taken |-> next_pc == word_t'(pc + word_t'(1)))
		else $error("next_pc is not pc + 1 on a not-taken prediction");

	// saturation at the top
	strongly_taken_holds: assert property (@(posedge clk)
		(reset_n && is_bj && actual_taken && prev_state == strongly_taken)
		|=> predictor_state == strongly_taken)
		else $error("counter left strongly_taken after a taken update");

endmodule

bind branch_predictor branch_predictor_checker u_checker (
	.clk             (clk),
	.reset_n         (reset_n),
	.pc              (pc),
	.is_bj           (is_bj),
	.actual_taken    (actual_taken),
	.prev_state      (prev_state),
	.next_pc         (next_pc),
	.taken           (taken),
	.predictor_state (predictor_state)
);

`default_nettype wire

//--- test/branch_predictor_tb.sv
`timescale 1ns/1ps
`default_nettype none

module branch_predictor_tb
	import pred_cfg_pkg::*;
	import pred_state_pkg::*;
();

	localparam int          clk_period      = 4;
	localparam int          reset_cycles    = 3;
	localparam int          check_delay     = 1;   // ns after the falling edge
	localparam int          watchdog_margin = 100; // ns
	localparam int unsigned seed            = 32'hd530_cd7d;
	localparam string       tests_file      = "test/branch_predictor_tests.txt";

	// one line of the tests file
	typedef struct packed {
		logic           rnd;
		logic           reset_n;
		word_t          pc;
		logic           is_bj;
		word_t          branch_pc;
		word_t          actual_pc;
		logic           actual_taken;
		counter_state_t prev_state;
		logic           exp_taken;
		word_t          exp_next_pc;
		counter_state_t exp_state;
	} vector_t;

	logic           clk;
	logic           gen_reset_n;
	logic           vec_reset_n;
	logic           reset_n;
	word_t          pc;
	logic           is_bj;
	word_t          branch_pc;
	word_t          actual_pc;
	logic           actual_taken;
	counter_state_t prev_state;
	word_t          next_pc;
	logic           taken;
	counter_state_t predictor_state;

	vector_t vectors[$];
	string   names[$];
	int      errors;
	int      tests_failed;
	bit      loaded;

	tb_clock_gen #(
		.period_ns    (clk_period),
		.reset_cycles (reset_cycles)
	) u_clock_gen (
		.clk     (clk),
		.reset_n (gen_reset_n)
	);

	// a vector can pull reset low on top of the power-on reset
	assign reset_n = gen_reset_n && vec_reset_n;

	branch_predictor u_dut (
		.clk             (clk),
		.reset_n         (reset_n),
		.pc              (pc),
		.is_bj           (is_bj),
		.branch_pc       (branch_pc),
		.actual_pc       (actual_pc),
		.actual_taken    (actual_taken),
		.prev_state      (prev_state),
		.next_pc         (next_pc),
		.taken           (taken),
		.predictor_state (predictor_state)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$finish;
	endtask

	task automatic load_vectors(output bit ok);
		int          fd;
		int          got;
		string       line;
		string       name;
		logic [31:0] f [11];
		vector_t     v;
		ok = 1'b0;
		fd = $fopen(tests_file, "r");
		if (fd != 0) begin
			ok = 1'b1;
			while (!$feof(fd)) begin
				line = "";
				got = $fgets(line, fd);
				if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
					got = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h", name,
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
					if (got != 12) begin
						$display("malformed line in %s: %s", tests_file, line);
						ok = 1'b0;
					end else begin
						v.rnd          = f[0][0];
						v.reset_n      = f[1][0];
						v.pc           = f[2][word_size-1:0];
						v.is_bj        = f[3][0];
						v.branch_pc    = f[4][word_size-1:0];
						v.actual_pc    = f[5][word_size-1:0];
						v.actual_taken = f[6][0];
						v.prev_state   = counter_state_t'(f[7][1:0]);
						v.exp_taken    = f[8][0];
						v.exp_next_pc  = f[9][word_size-1:0];
						v.exp_state    = counter_state_t'(f[10][1:0]);
						vectors.push_back(v);
						names.push_back(name);
					end
				end
			end
			$fclose(fd);
			if (vectors.size() == 0) begin
				ok = 1'b0;
			end
		end
	endtask

	task automatic run_vector(input int idx);
		vector_t     v;
		word_t       exp_next_pc;
		logic [31:0] rnd_word;
		int          errors_before;
		v = vectors[idx];
		exp_next_pc = v.exp_next_pc;
		if (v.rnd) begin
			rnd_word = $urandom();
			v.pc = rnd_word[word_size-1:0];
			exp_next_pc = v.pc + word_t'(1); // counter is not taken on these lines
		end
		@(negedge clk);
		vec_reset_n  = v.reset_n;
		pc           = v.pc;
		is_bj        = v.is_bj;
		branch_pc    = v.branch_pc;
		actual_pc    = v.actual_pc;
		actual_taken = v.actual_taken;
		prev_state   = v.prev_state;
		#(check_delay);
		errors_before = errors;
		assert (taken === v.exp_taken) else begin
			$display("FAILED %s taken expected %h got %h", names[idx], v.exp_taken, taken);
			errors++;
		end
		assert (next_pc === exp_next_pc) else begin
			$display("FAILED %s next_pc expected %h got %h", names[idx], exp_next_pc, next_pc);
			errors++;
		end
		assert (predictor_state === v.exp_state) else begin
			$display("FAILED %s predictor_state expected %h got %h", names[idx], v.exp_state,
				predictor_state);
			errors++;
		end
		if (errors == errors_before) begin
			$display("test %0d %s ok", idx, names[idx]);
		end else begin
			$display("test %0d %s mismatch", idx, names[idx]);
			tests_failed++;
		end
	endtask

	initial begin
		bit ok;
		vec_reset_n  = 1'b1;
		pc           = '0;
		is_bj        = 1'b0;
		branch_pc    = '0;
		actual_pc    = '0;
		actual_taken = 1'b0;
		prev_state   = strongly_not_taken;
		errors       = 0;
		tests_failed = 0;
		loaded       = 1'b0;
		void'($urandom(seed)); // seeds the generator for the whole run
		load_vectors(ok);
		if (!ok) begin
			abort_run("could not read the test vectors");
		end else begin
			loaded = 1'b1;
			wait (gen_reset_n);
			for (int i = 0; i < vectors.size(); i++) begin
				run_vector(i);
			end
			$display("%0d tests run, %0d failed, %0d check errors", vectors.size(),
				tests_failed, errors);
			if (errors == 0) begin
				$display("TEST PASSED");
			end else begin
				$display("TEST FAILED");
			end
			$finish;
		end
	end

	// two clock periods per vector leaves room for the power-on reset
	initial begin : watchdog
		int timeout_ns;
		wait (loaded);
		timeout_ns = vectors.size() * clk_period * 2 + watchdog_margin;
		#(timeout_ns);
		abort_run("the run timed out before all tests finished");
	end

endmodule

`default_nettype wire

//--- filelist.f
// packages
source/pred_cfg_pkg.sv
source/pred_state_pkg.sv
// design
source/target_buffer.sv
source/direction_counter.sv
source/branch_predictor.sv
// testbench
test/tb_clock_gen.sv
test/branch_predictor_checker.sv
test/branch_predictor_tb.sv

//--- Makefile
# Verilator build and run for the branch predictor testbench
# every variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= branch_predictor_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

FAIL_MSG := TEST FAILED
PASS_MSG := TEST PASSED

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test build clean

help:
	@echo "targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

test: build
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/branch_predictor_tests.txt
# name rnd reset_n pc is_bj branch_pc actual_pc actual_taken prev_state taken next_pc state
# all values in hex; rnd 1 draws pc at random and expects pc + 1
# after power-on reset
after_reset      0 1 0100 0 0000 0000 0 0 0 0101 0
after_reset_wrap 0 1 ffff 0 0000 0000 0 0 0 0000 0
idle_random      1 1 0000 0 0000 0000 0 0 0 0000 0
idle_random      1 1 0000 0 0000 0000 0 0 0 0000 0
# counter climbs and saturates, entry 10 learns target 0200
train_alloc      0 1 0010 1 0010 0200 1 0 0 0011 0
sat_up           0 1 0010 1 0010 0200 1 1 0 0011 1
predict_hit      0 1 0010 0 0000 0000 0 0 1 0200 2
sat_up           0 1 0010 1 0010 0200 1 2 1 0200 2
sat_up           0 1 0010 1 0010 0200 1 3 1 0200 3
sat_hold_high    0 1 0010 0 0000 0000 0 0 1 0200 3
predict_miss     0 1 0020 0 0000 0000 0 0 0 0021 3
# not-taken update leaves entry 30 invalid
nt_no_alloc      0 1 0020 1 0030 0400 0 3 0 0021 3
nt_lookup        0 1 0030 0 0000 0000 0 0 0 0031 2
still_hit        0 1 0010 0 0000 0000 0 0 1 0200 2
# aliasing on index 10 and overwrite
alias_hit        0 1 0110 0 0000 0000 0 0 1 0200 2
overwrite        0 1 0010 1 0410 0300 1 2 1 0200 2
overwrite_seen   0 1 0010 0 0000 0000 0 0 1 0300 3
overwrite_alias  0 1 0110 0 0000 0000 0 0 1 0300 3
# counter walks back down and holds at zero
sat_down         0 1 0010 1 0050 0000 0 3 1 0300 3
sat_down         0 1 0010 1 0050 0000 0 2 1 0300 2
sat_down         0 1 0010 1 0050 0000 0 1 0 0011 1
sat_down         0 1 0010 1 0050 0000 0 0 0 0011 0
sat_hold_low     0 1 0010 0 0000 0000 0 0 0 0011 0
idle_random      1 1 0000 0 0000 0000 0 0 0 0000 0
idle_random      1 1 0000 0 0000 0000 0 0 0 0000 0
# next state follows prev_state and not the live counter
snapshot_update  0 1 0040 1 0040 0500 1 2 0 0041 0
snapshot_seen    0 1 0040 0 0000 0000 0 0 1 0500 3
# reset in the middle of the run
mid_reset        0 0 0040 0 0000 0000 0 0 1 0500 3
mid_reset        0 0 0040 0 0000 0000 0 0 0 0041 0
after_mid_reset  0 1 0040 0 0000 0000 0 0 0 0041 0
after_mid_reset  0 1 0010 0 0000 0000 0 0 0 0011 0
retrain          0 1 0010 1 0077 0600 1 2 0 0011 0
cleared_btb      0 1 0010 0 0000 0000 0 0 0 0011 3
cleared_btb      0 1 0040 0 0000 0000 0 0 0 0041 3
cleared_btb      0 1 0110 0 0000 0000 0 0 0 0111 3
fresh_hit        0 1 0077 0 0000 0000 0 0 1 0600 3
miss_wrap        0 1 ffff 0 0000 0000 0 0 0 0000 3
